//--- filelist.f
hdl/lc3b_types.sv
hdl/eviction_wb_plru.sv
hdl/eviction_wb_datapath.sv
hdl/eviction_wb_control.sv
hdl/eviction_wb.sv
testbench/eviction_wb_checker.sv
testbench/eviction_wb_tb.sv

//--- hdl/eviction_wb.sv
`timescale 1ns/1ps

module eviction_wb
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     req_valid,
	output logic                     req_ready,
	input  lc3b_types::wb_req_t      req,
	output logic                     resp_valid,
	output lc3b_types::wb_resp_t     resp,
	output lc3b_types::wb_pmem_req_t pmem,
	input  lc3b_types::lc3b_data     pmem_rdata,
	input  logic                     pmem_resp
);

import lc3b_types::*;

logic       load_req;
logic       store;
wb_index_t  store_index;
logic       clear;
wb_index_t  clear_index;
wb_index_t  wb_index;
logic       capture_pmem;
logic       hit;
wb_index_t  hit_index;
logic [3:0] valid_mask;
wb_index_t  victim;
logic       access;
wb_index_t  access_index;
logic       pmem_read;
logic       pmem_write;
lc3b_data   rdata;
lc3b_word   wb_address;
lc3b_data   wb_data;

eviction_wb_control control
(
	.clk(clk),
	.arst_n(arst_n),
	.req_valid(req_valid),
	.req_ready(req_ready),
	.op(req.op),
	.hit(hit),
	.hit_index(hit_index),
	.valid_mask(valid_mask),
	.victim(victim),
	.pmem_resp(pmem_resp),
	.load_req(load_req),
	.store(store),
	.store_index(store_index),
	.clear(clear),
	.clear_index(clear_index),
	.wb_index(wb_index),
	.capture_pmem(capture_pmem),
	.access(access),
	.access_index(access_index),
	.resp_valid(resp_valid),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write)
);

eviction_wb_datapath datapath
(
	.clk(clk),
	.arst_n(arst_n),
	.req(req),
	.load_req(load_req),
	.store(store),
	.store_index(store_index),
	.clear(clear),
	.clear_index(clear_index),
	.wb_index(wb_index),
	.pmem_rdata(pmem_rdata),
	.capture_pmem(capture_pmem),
	.hit(hit),
	.hit_index(hit_index),
	.valid_mask(valid_mask),
	.rdata(rdata),
	.wb_address(wb_address),
	.wb_data(wb_data)
);

eviction_wb_plru plru
(
	.clk(clk),
	.arst_n(arst_n),
	.access(access),
	.access_index(access_index),
	.victim(victim)
);

assign resp.rdata = rdata;
assign pmem       = {pmem_read, pmem_write, wb_address, wb_data};

endmodule: eviction_wb

//--- hdl/eviction_wb_control.sv
`timescale 1ns/1ps

module eviction_wb_control
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  lc3b_types::wb_op_t    op,
	input  logic                  hit,
	input  lc3b_types::wb_index_t hit_index,
	input  logic [3:0]            valid_mask,
	input  lc3b_types::wb_index_t victim,
	input  logic                  pmem_resp,
	output logic                  load_req,
	output logic                  store,
	output lc3b_types::wb_index_t store_index,
	output logic                  clear,
	output lc3b_types::wb_index_t clear_index,
	output lc3b_types::wb_index_t wb_index,
	output logic                  capture_pmem,
	output logic                  access,
	output lc3b_types::wb_index_t access_index,
	output logic                  resp_valid,
	output logic                  pmem_read,
	output logic                  pmem_write
);

import lc3b_types::*;

wb_state_t state, next_state;
logic      started;      // first cycle after reset has passed
logic      hit_resp;
logic      miss_resp_q;  // memory data lands in the cycle after pmem_resp
wb_index_t lowest_valid;
wb_index_t lowest_free;

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		state       <= wb_idle;
		started     <= 1'b0;
		miss_resp_q <= 1'b0;
	end
	else
	begin
		state       <= next_state;
		started     <= 1'b1;
		miss_resp_q <= capture_pmem;
	end
end

// priority pick with the lowest number winning
always_comb
begin
	lowest_valid = 2'd0;
	lowest_free  = 2'd0;
	for (int i = 3; i >= 0; i--)
	begin
		if (valid_mask[i])
			lowest_valid = wb_index_t'(i);
		else
			lowest_free = wb_index_t'(i);
	end
end

// ======================================================================
// next state and strobes
// ======================================================================
always_comb
begin
	next_state   = state;
	load_req     = 1'b0;
	store        = 1'b0;
	store_index  = hit_index;
	clear        = 1'b0;
	clear_index  = lowest_valid;
	wb_index     = lowest_valid;
	capture_pmem = 1'b0;
	pmem_read    = 1'b0;
	pmem_write   = 1'b0;
	hit_resp     = 1'b0;
	case (state)
		wb_idle:
			if (started && req_valid)
			begin
				load_req   = 1'b1;
				next_state = (op == wb_op_read) ? wb_hit_resp : wb_alloc;
			end
			else if (started && |valid_mask)
				next_state = wb_drain;
		wb_hit_resp:
			if (hit)
			begin
				hit_resp   = 1'b1;
				next_state = wb_idle;
			end
			else
			begin
				pmem_read = 1'b1; // miss goes straight out
				if (pmem_resp)
				begin
					capture_pmem = 1'b1;
					next_state   = wb_idle;
				end
				else
					next_state = wb_read_mem;
			end
		wb_read_mem:
		begin
			pmem_read = 1'b1;
			if (pmem_resp)
			begin
				capture_pmem = 1'b1;
				next_state   = wb_idle;
			end
		end
		wb_alloc:
			if (hit)
			begin
				store      = 1'b1;
				next_state = wb_idle;
			end
			else if (!(&valid_mask))
			begin
				store       = 1'b1;
				store_index = lowest_free;
				next_state  = wb_idle;
			end
			else
				next_state = wb_evict;
		wb_evict:
		begin
			wb_index   = victim;
			pmem_write = 1'b1;
			if (pmem_resp)
			begin
				clear       = 1'b1;
				clear_index = victim;
				next_state  = wb_alloc; // victim slot is now the only free one
			end
		end
		wb_drain:
		begin
			pmem_write = 1'b1;
			if (pmem_resp)
			begin
				clear      = 1'b1;
				next_state = wb_idle;
			end
		end
		default:
			next_state = wb_idle;
	endcase
end

assign req_ready    = (state == wb_idle) && started;
assign resp_valid   = hit_resp | miss_resp_q;
assign access       = hit_resp | store;
assign access_index = store ? store_index : hit_index;

assert property (@(posedge clk) disable iff (!arst_n) !(pmem_read && pmem_write));

// a missed line never overwrites an entry still waiting for write-back
assert property (@(posedge clk) disable iff (!arst_n)
	(store && !hit) |-> !valid_mask[store_index]);

// the evicted slot is the one refilled
assert property (@(posedge clk) disable iff (!arst_n)
	(state == wb_evict && pmem_resp) |=> (store && store_index == $past(victim)));

endmodule: eviction_wb_control

//--- hdl/eviction_wb_datapath.sv
`timescale 1ns/1ps

module eviction_wb_datapath
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  lc3b_types::wb_req_t   req,
	input  logic                  load_req,
	input  logic                  store,
	input  lc3b_types::wb_index_t store_index,
	input  logic                  clear,
	input  lc3b_types::wb_index_t clear_index,
	input  lc3b_types::wb_index_t wb_index,
	input  lc3b_types::lc3b_data  pmem_rdata,
	input  logic                  capture_pmem,
	output logic                  hit,
	output lc3b_types::wb_index_t hit_index,
	output logic [3:0]            valid_mask,
	output lc3b_types::lc3b_data  rdata,
	output lc3b_types::lc3b_word  wb_address,
	output lc3b_types::lc3b_data  wb_data
);

import lc3b_types::*;

wb_req_t    req_q;       // held request
lc3b_l2_tag req_tag;
logic       rd_pending;  // read accepted, not yet answered
lc3b_data   mem_line_q;  // line returned by memory on a miss

logic [3:0] valid;
lc3b_l2_tag tag_array [4];
lc3b_data   data_array [4];
logic [3:0] match;

assign req_tag = req_q.address[15:4];

// ======================================================================
// request and miss data registers
// ======================================================================
always_ff @(posedge clk)
begin
	if (load_req)
		req_q <= req;
	if (capture_pmem)
		mem_line_q <= pmem_rdata;
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		rd_pending <= 1'b0;
	else if (load_req)
		rd_pending <= (req.op == wb_op_read);
	else if (capture_pmem || hit)
		rd_pending <= 1'b0; // answered from memory or from an entry
end

// ======================================================================
// entry arrays
// ======================================================================
always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		valid <= 4'b0000;
	else
	begin
		if (clear)
			valid[clear_index] <= 1'b0;
		if (store)
			valid[store_index] <= 1'b1;
	end
end

always_ff @(posedge clk)
begin
	if (store)
	begin
		tag_array[store_index]  <= req_tag;
		data_array[store_index] <= req_q.wdata;
	end
end

assign valid_mask = valid;

// ======================================================================
// tag compare and hit encoding
// ======================================================================
always_comb
begin
	for (int i = 0; i < 4; i++)
		match[i] = valid[i] && (tag_array[i] == req_tag);
end

assign hit = |match;

always_comb
begin
	if (match[0])
		hit_index = 2'd0;
	else if (match[1])
		hit_index = 2'd1;
	else if (match[2])
		hit_index = 2'd2;
	else
		hit_index = 2'd3;
end

// response line, buffered entry or memory copy
assign rdata = hit ? data_array[hit_index] : mem_line_q;

// memory address: the missed line while a read waits, else the write-back entry
assign wb_address = rd_pending ? {req_tag, 4'b0000} : {tag_array[wb_index], 4'b0000};
assign wb_data    = data_array[wb_index];

// a line lives in at most one entry, across every store and clear
assert property (@(posedge clk) disable iff (!arst_n) $onehot0(match));

endmodule: eviction_wb_datapath

//--- hdl/eviction_wb_plru.sv
`timescale 1ns/1ps

module eviction_wb_plru
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  access,
	input  lc3b_types::wb_index_t access_index,
	output lc3b_types::wb_index_t victim
);

// tree[0] picks the pair, tree[1] inside pair 0, tree[2] inside pair 1
logic [2:0] tree;

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		tree <= 3'b000;
	else if (access)
	begin
		tree[0] <= ~access_index[1]; // point root at the other pair
		if (access_index[1])
			tree[2] <= ~access_index[0];
		else
			tree[1] <= ~access_index[0];
	end
end

// follow the bits down to a leaf
always_comb
begin
	victim[1] = tree[0];
	if (tree[0])
		victim[0] = tree[2];
	else
		victim[0] = tree[1];
end

endmodule: eviction_wb_plru

//--- hdl/lc3b_types.sv
package lc3b_types;

// ======================================================================
// basic widths
// ======================================================================
typedef logic [15:0]  lc3b_word;    // byte address
typedef logic [127:0] lc3b_data;    // one cache line
typedef logic [11:0]  lc3b_l2_tag;  // address bits 15:4
typedef logic [1:0]   wb_index_t;   // buffer entry number

typedef enum logic
{
	wb_op_read,
	wb_op_write
} wb_op_t;

typedef enum logic [2:0]
{
	wb_idle,
	wb_hit_resp,  // lookup after a read, answers on hit
	wb_read_mem,  // read miss waiting on memory
	wb_evict,     // victim write-back before allocation
	wb_drain,     // idle-time write-back
	wb_alloc      // write lookup and store
} wb_state_t;

// ======================================================================
// channel structs
// ======================================================================
typedef struct packed
{
	wb_op_t   op;
	lc3b_word address;
	lc3b_data wdata;
} wb_req_t;

typedef struct packed
{
	lc3b_data rdata;
} wb_resp_t;

typedef struct packed
{
	logic     read;
	logic     write;
	lc3b_word address;
	lc3b_data wdata;
} wb_pmem_req_t;

endpackage: lc3b_types

//--- testbench/eviction_wb_checker.sv
`timescale 1ns/1ps

module eviction_wb_checker
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     req_valid,
	input  logic                     req_ready,
	input  lc3b_types::wb_req_t      req,
	input  logic                     resp_valid,
	input  lc3b_types::wb_resp_t     resp,
	input  lc3b_types::wb_pmem_req_t pmem,
	input  logic                     pmem_resp,
	output int                       error_count,
	output logic                     read_open
);

import lc3b_types::*;

lc3b_data   shadow_line [4096];  // latest line written per tag
logic       written [4096];
lc3b_word   read_address;        // read waiting for its response
logic       seen_req;
lc3b_l2_tag tag;

initial
begin
	error_count = 0;
	read_open   = 1'b0;
	seen_req    = 1'b0;
	for (int i = 0; i < 4096; i++)
		written[i] = 1'b0;
end

// memory content before any write-back
function automatic lc3b_data initial_line(input lc3b_l2_tag line_tag);
	lc3b_data line;
	for (int j = 0; j < 8; j++)
		line[j*16 +: 16] = {line_tag, 4'(j * 2)} ^ 16'h5a3c;
	return line;
endfunction

function lc3b_data expected_line(input lc3b_word addr);
	if (written[addr[15:4]])
		return shadow_line[addr[15:4]];
	return initial_line(addr[15:4]);
endfunction

task show_mismatch(input string name, input logic [127:0] exp, input logic [127:0] got);
	$display("MISMATCH %s: expected %0h, got %0h", name, exp, got);
	error_count++;
endtask

task count_failure(input string what);
	$display("%s", what);
	error_count++;
endtask

// responses first, since a new request can be accepted on the same edge
always @(posedge clk)
begin
	if (arst_n)
	begin
		if (pmem.read && pmem.write)
			count_failure("memory read and write were asserted together");
		if (!seen_req && (resp_valid || pmem.read || pmem.write))
			count_failure("DUT was active before the first request");

		if (resp_valid)
		begin
			if (!read_open)
				count_failure("response pulse without a pending read");
			else
			begin
				if (resp.rdata !== expected_line(read_address))
					show_mismatch("resp.rdata", expected_line(read_address), resp.rdata);
				read_open = 1'b0;
			end
		end

		if (pmem_resp && pmem.read)
		begin
			if (pmem.address !== {read_address[15:4], 4'h0})
				show_mismatch("pmem.address", {read_address[15:4], 4'h0}, pmem.address);
		end

		if (pmem_resp && pmem.write)
		begin
			tag = pmem.address[15:4];
			if (pmem.address[3:0] !== 4'h0)
				show_mismatch("pmem.address", {tag, 4'h0}, pmem.address);
			if (!written[tag])
				count_failure($sformatf("write-back of line %h that was never written", tag));
			else if (pmem.wdata !== shadow_line[tag])
				show_mismatch("pmem.wdata", shadow_line[tag], pmem.wdata);
		end

		if (req_valid && req_ready)
		begin
			seen_req = 1'b1;
			if (read_open)
				count_failure($sformatf("read of %h got no response", read_address));
			if (req.op == wb_op_read)
			begin
				read_address = req.address;
				read_open    = 1'b1;
			end
			else
			begin
				shadow_line[req.address[15:4]] = req.wdata;
				written[req.address[15:4]]     = 1'b1;
				read_open                      = 1'b0;
			end
		end
	end
end

endmodule: eviction_wb_checker

//--- testbench/eviction_wb_tb.sv
`timescale 1ns/1ps

module eviction_wb_tb;

import lc3b_types::*;

localparam int NUM_REQ   = 400;
localparam int MEM_DELAY = 3;              // cycles until pmem_resp
localparam int LIMIT     = NUM_REQ * 20;
localparam int QUIET     = 20;             // idle cycles that mark a full drain

logic         clk;
logic         arst_n;
logic         req_valid;
logic         req_ready;
wb_req_t      req;
logic         resp_valid;
wb_resp_t     resp;
wb_pmem_req_t pmem;
lc3b_data     pmem_rdata;
logic         pmem_resp;

int         error_count;  // counted by the checker
logic       read_open;
int         mem_errors;
int         cycles;
int         mem_wait;
int         quiet_count;
int         gap;
integer     seed;
wb_op_t     op;
lc3b_word   address;
lc3b_word   last_address;
logic       last_write;
lc3b_data   expected;
lc3b_data   mem [4096];

eviction_wb UUT
(
	.clk(clk),
	.arst_n(arst_n),
	.req_valid(req_valid),
	.req_ready(req_ready),
	.req(req),
	.resp_valid(resp_valid),
	.resp(resp),
	.pmem(pmem),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp)
);

eviction_wb_checker check
(
	.clk(clk),
	.arst_n(arst_n),
	.req_valid(req_valid),
	.req_ready(req_ready),
	.req(req),
	.resp_valid(resp_valid),
	.resp(resp),
	.pmem(pmem),
	.pmem_resp(pmem_resp),
	.error_count(error_count),
	.read_open(read_open)
);

initial
	clk = 1'b0;

always #5 clk = ~clk;

// each 16-bit word mixes the line tag with its own byte offset
function automatic lc3b_data fill_line(input lc3b_l2_tag tag);
	lc3b_data line;
	for (int j = 0; j < 8; j++)
		line[j*16 +: 16] = {tag, 4'(j * 2)} ^ 16'h5a3c;
	return line;
endfunction

function automatic lc3b_word pool_address(input int idx);
	case (idx)
		0: return 16'h0000;
		1: return 16'h1230;
		2: return 16'h4560;
		3: return 16'h7890;
		4: return 16'habc0;
		default: return 16'hfff0;
	endcase
endfunction

function lc3b_data random_line();
	return {$random(seed), $random(seed), $random(seed), $random(seed)};
endfunction

// called on a falling edge, returns on the falling edge after acceptance
task send_request(input wb_op_t kind, input lc3b_word addr, input lc3b_data data);
	req_valid     = 1'b1;
	req.op        = kind;
	req.address   = addr;
	req.wdata     = data;
	while (!req_ready)
		@(negedge clk);
	@(negedge clk);
	req_valid = 1'b0;
endtask

task report_counts();
	$display("checker errors: %0d, memory model errors: %0d", error_count, mem_errors);
endtask

// ======================================================================
// physical memory model
// ======================================================================
always @(negedge clk)
begin
	if (!arst_n)
	begin
		pmem_resp = 1'b0;
		mem_wait  = 0;
	end
	else if (pmem_resp)
	begin
		pmem_resp = 1'b0; // request drops on the next edge
		mem_wait  = 0;
	end
	else if (pmem.read || pmem.write)
	begin
		mem_wait++;
		if (mem_wait == MEM_DELAY)
		begin
			pmem_resp = 1'b1;
			if (pmem.read)
				pmem_rdata = mem[pmem.address[15:4]];
			else
				mem[pmem.address[15:4]] = pmem.wdata;
		end
	end
end

always @(posedge clk)
begin
	cycles++;
	if (cycles >= LIMIT)
	begin
		$display("timeout: run did not finish within %0d cycles", LIMIT);
		report_counts();
		$display("TEST RESULT: FAIL");
		$finish;
	end
end

// ======================================================================
// stimulus and final memory compare
// ======================================================================
initial
begin
	seed         = 13645;
	cycles       = 0;
	mem_errors   = 0;
	arst_n       = 1'b0;
	req_valid    = 1'b0;
	req          = '0;
	pmem_rdata   = '0;
	pmem_resp    = 1'b0;
	mem_wait     = 0;
	last_address = 16'h0000;
	last_write   = 1'b0;
	for (int i = 0; i < 4096; i++)
		mem[i] = fill_line(i[11:0]);

	repeat (10) @(negedge clk);
	arst_n = 1'b1;

	for (int n = 0; n < NUM_REQ; n++)
	begin
		gap = $random(seed) & 7;
		if (gap > 3)
			repeat (gap - 3) @(negedge clk); // idle time lets drains start
		if (last_write && (($random(seed) & 3) != 0))
		begin
			op      = wb_op_read; // read back what was just written
			address = last_address;
		end
		else
		begin
			op      = ($random(seed) & 1) ? wb_op_write : wb_op_read;
			address = pool_address($unsigned($random(seed)) % 6) | 16'($random(seed) & 15);
		end
		send_request(op, address, random_line());
		last_write   = (op == wb_op_write);
		last_address = address;
	end

	quiet_count = 0;
	while (quiet_count < QUIET)
	begin
		@(negedge clk);
		if (req_ready && !pmem.read && !pmem.write)
			quiet_count++;
		else
			quiet_count = 0;
	end

	for (int i = 0; i < 4096; i++)
	begin
		expected = check.expected_line({i[11:0], 4'h0});
		if (mem[i] !== expected)
		begin
			$display("MISMATCH mem[%h]: expected %h, got %h", i[11:0], expected, mem[i]);
			mem_errors++;
		end
	end
	if (read_open)
	begin
		$display("the last read never got a response");
		mem_errors++;
	end

	report_counts();
	if (error_count == 0 && mem_errors == 0)
		$display("TEST RESULT: PASS");
	else
		$display("TEST RESULT: FAIL");
	$finish;
end

endmodule: eviction_wb_tb
